// File: src/cpu_types_pkg.sv
package cpu_types_pkg;

   localparam int DATA_W    = 32;
   localparam int IMM_W     = 16;
   localparam int FLAG_W    = 8;
   localparam int NUM_REGS  = 16;
   localparam int REG_IDX_W = $clog2(NUM_REGS);

   typedef logic [DATA_W-1:0]    word_t;
   typedef logic [IMM_W-1:0]     imm_t;
   typedef logic [FLAG_W-1:0]    flags_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // positions in the flag byte
   localparam int C_IDX  = 0;  // carry
   localparam int V_IDX  = 1;  // overflow
   localparam int Z_IDX  = 2;  // zero
   localparam int S_IDX  = 3;  // sign
   localparam int P_IDX  = 4;  // user bits from here up
   localparam int U_IDX  = 5;
   localparam int N1_IDX = 6;
   localparam int N2_IDX = 7;

endpackage

// File: src/alu_op_pkg.sv
package alu_op_pkg;

   localparam int OP_W = 6;

   typedef logic [OP_W-1:0] opcode_t;

   localparam int CLASS1_BIT = 5;  // one-operand class
   localparam int IMM_BIT    = 4;  // register-immediate when class1 clear

   // register-register class
   localparam opcode_t OP_MOV  = 6'h00;
   localparam opcode_t OP_SED  = 6'h03;  // fill with sign of rs
   localparam opcode_t OP_ADD  = 6'h04;
   localparam opcode_t OP_ADC  = 6'h05;
   localparam opcode_t OP_SUB  = 6'h06;
   localparam opcode_t OP_SBB  = 6'h07;
   localparam opcode_t OP_CMP  = 6'h08;
   localparam opcode_t OP_MUL  = 6'h09;
   localparam opcode_t OP_PLUS = 6'h0a;  // add without flags
   localparam opcode_t OP_TEST = 6'h0c;
   localparam opcode_t OP_OR   = 6'h0d;
   localparam opcode_t OP_XOR  = 6'h0e;
   localparam opcode_t OP_AND  = 6'h0f;

   // register-immediate class
   localparam opcode_t OP_MVL   = 6'h10;
   localparam opcode_t OP_MVH   = 6'h11;
   localparam opcode_t OP_MVZL  = 6'h12;
   localparam opcode_t OP_MVS   = 6'h13;
   localparam opcode_t OP_ADDI  = 6'h14;
   localparam opcode_t OP_ADCI  = 6'h15;
   localparam opcode_t OP_SUBI  = 6'h16;
   localparam opcode_t OP_SBBI  = 6'h17;
   localparam opcode_t OP_CMPI  = 6'h18;
   localparam opcode_t OP_MULI  = 6'h19;
   localparam opcode_t OP_PLUSI = 6'h1a;
   localparam opcode_t OP_TESTI = 6'h1c;
   localparam opcode_t OP_ORI   = 6'h1d;
   localparam opcode_t OP_XORI  = 6'h1e;
   localparam opcode_t OP_ANDI  = 6'h1f;  // immediate is one-extended

   // one-operand class
   localparam opcode_t OP_ZEB  = 6'h20;
   localparam opcode_t OP_ZEW  = 6'h21;
   localparam opcode_t OP_SEB  = 6'h22;
   localparam opcode_t OP_SEW  = 6'h23;
   localparam opcode_t OP_NOT  = 6'h24;
   localparam opcode_t OP_NEG  = 6'h25;
   localparam opcode_t OP_ROR  = 6'h26;  // through carry
   localparam opcode_t OP_ROL  = 6'h27;  // through carry
   localparam opcode_t OP_SHL  = 6'h28;
   localparam opcode_t OP_SHR  = 6'h29;
   localparam opcode_t OP_SHA  = 6'h2a;
   localparam opcode_t OP_GETF = 6'h2e;
   localparam opcode_t OP_SETF = 6'h2f;

endpackage

// File: src/adder.sv
module adder #(
   parameter int WIDTH = 32
) (
   input  logic [WIDTH-1:0] ai,
   input  logic [WIDTH-1:0] bi,
   input  logic             ci,
   output logic [WIDTH-1:0] res,
   output logic             co,
   output logic             vo
);

   logic [WIDTH:0] sum;

   assign sum = {1'b0, ai} + {1'b0, bi} + {{WIDTH{1'b0}}, ci};
   assign res = sum[WIDTH-1:0];
   assign co  = sum[WIDTH];

   // same operand signs, result sign differs
   assign vo = (ai[WIDTH-1] == bi[WIDTH-1]) && (res[WIDTH-1] != ai[WIDTH-1]);

endmodule

// File: src/alu.sv
module alu
   import cpu_types_pkg::*;
   import alu_op_pkg::*;
(
   input  opcode_t op,
   input  flags_t  fi,
   input  word_t   di,
   input  word_t   bi,
   input  imm_t    im,
   output word_t   res,
   output flags_t  fo,
   output logic    wb_en,
   output logic    flag_en
);

   logic [3:0] fn;
   logic       op_1;
   logic       op_2im;
   logic       op_2reg;
   logic       is_neg;
   logic       is_setf;
   word_t      zex_im;
   word_t      sex_im;
   word_t      oex_im;
   word_t      op2;
   word_t      add_a;
   word_t      add_b;
   word_t      add_res;
   logic       add_ci;
   logic       add_co;
   logic       add_vo;
   word_t      res_2;
   word_t      res_1;
   logic       c_new;
   logic       v_new;

   assign fn      = op[3:0];
   assign op_1    = op[CLASS1_BIT];
   assign op_2im  = !op_1 && op[IMM_BIT];
   assign op_2reg = !op_1 && !op[IMM_BIT];
   assign is_neg  = (op == OP_NEG);
   assign is_setf = (op == OP_SETF);

   assign zex_im = {{(DATA_W-IMM_W){1'b0}}, im};
   assign sex_im = {{(DATA_W-IMM_W){im[IMM_W-1]}}, im};
   assign oex_im = {{(DATA_W-IMM_W){1'b1}}, im};

   // second operand, arithmetic immediates are sign-extended
   always_comb begin
      op2 = bi;
      if (op_2im) begin
         if (fn inside {OP_MVL[3:0], OP_MVH[3:0], OP_MVZL[3:0], 4'hb,
                        OP_TESTI[3:0], OP_ORI[3:0], OP_XORI[3:0]})
            op2 = zex_im;
         else if (fn == OP_ANDI[3:0])
            op2 = oex_im;
         else
            op2 = sex_im;
      end
   end

   always_comb begin
      add_a  = di;
      add_b  = op2;
      add_ci = 1'b0;
      if (is_neg) begin  // 0 - di
         add_a  = '0;
         add_b  = ~di;
         add_ci = 1'b1;
      end else begin
         case (fn)
            OP_ADC[3:0]: add_ci = fi[C_IDX];
            OP_SUB[3:0], OP_CMP[3:0]: begin
               add_b  = ~op2;
               add_ci = 1'b1;
            end
            OP_SBB[3:0]: begin
               add_b  = ~op2;
               add_ci = fi[C_IDX];  // C set means no borrow
            end
            default: add_ci = 1'b0;
         endcase
      end
   end

   adder #(.WIDTH(DATA_W)) adder_i (
      .ai  (add_a),
      .bi  (add_b),
      .ci  (add_ci),
      .res (add_res),
      .co  (add_co),
      .vo  (add_vo)
   );

   always_comb begin
      case (fn)
         OP_MOV[3:0]:  res_2 = op_2reg ? op2 : {di[DATA_W-1:IMM_W], op2[IMM_W-1:0]};
         OP_MVH[3:0]:  res_2 = op_2reg ? di : {op2[IMM_W-1:0], di[IMM_W-1:0]};
         OP_MVZL[3:0]: res_2 = op_2reg ? di : op2;
         OP_SED[3:0]:  res_2 = op_2reg ? {DATA_W{op2[DATA_W-1]}} : op2;
         OP_MUL[3:0]:  res_2 = di * op2;  // low word only
         OP_OR[3:0]:   res_2 = di | op2;
         OP_XOR[3:0]:  res_2 = di ^ op2;
         4'hb, OP_TEST[3:0], OP_AND[3:0]:
            res_2 = di & op2;
         default:      res_2 = add_res;
      endcase
   end

   always_comb begin
      case (fn)
         OP_ZEB[3:0]:  res_1 = {{(DATA_W-8){1'b0}}, di[7:0]};
         OP_ZEW[3:0]:  res_1 = {{(DATA_W-IMM_W){1'b0}}, di[IMM_W-1:0]};
         OP_SEB[3:0]:  res_1 = {{(DATA_W-8){di[7]}}, di[7:0]};
         OP_SEW[3:0]:  res_1 = {{(DATA_W-IMM_W){di[IMM_W-1]}}, di[IMM_W-1:0]};
         OP_NOT[3:0]:  res_1 = ~di;
         OP_NEG[3:0]:  res_1 = add_res;
         OP_ROR[3:0]:  res_1 = {fi[C_IDX], di[DATA_W-1:1]};
         OP_ROL[3:0]:  res_1 = {di[DATA_W-2:0], fi[C_IDX]};
         OP_SHL[3:0]:  res_1 = {di[DATA_W-2:0], 1'b0};
         OP_SHR[3:0]:  res_1 = {1'b0, di[DATA_W-1:1]};
         OP_SHA[3:0]:  res_1 = {di[DATA_W-1], di[DATA_W-1:1]};
         OP_GETF[3:0]: res_1 = {{(DATA_W-FLAG_W){1'b0}}, fi};
         default:      res_1 = di;
      endcase
   end

   assign res = op_1 ? res_1 : res_2;

   // carry and overflow
   always_comb begin
      c_new = fi[C_IDX];
      v_new = fi[V_IDX];
      if (op_1) begin
         case (fn)
            OP_NEG[3:0]: begin
               c_new = add_co;
               v_new = add_vo;
            end
            OP_ROR[3:0], OP_SHR[3:0], OP_SHA[3:0]:
               c_new = di[0];  // bit shifted out
            OP_ROL[3:0], OP_SHL[3:0]:
               c_new = di[DATA_W-1];
            default: c_new = fi[C_IDX];
         endcase
      end else if (fn inside {[OP_ADD[3:0]:OP_CMP[3:0]]}) begin
         c_new = add_co;
         v_new = add_vo;
      end
   end

   assign fo[C_IDX]  = is_setf ? di[C_IDX]  : c_new;
   assign fo[V_IDX]  = is_setf ? di[V_IDX]  : v_new;
   assign fo[Z_IDX]  = is_setf ? di[Z_IDX]  : ~|res;
   assign fo[S_IDX]  = is_setf ? di[S_IDX]  : res[DATA_W-1];
   assign fo[P_IDX]  = is_setf ? di[P_IDX]  : fi[P_IDX];
   assign fo[U_IDX]  = is_setf ? di[U_IDX]  : fi[U_IDX];
   assign fo[N1_IDX] = is_setf ? di[N1_IDX] : fi[N1_IDX];
   assign fo[N2_IDX] = is_setf ? di[N2_IDX] : fi[N2_IDX];

   // enables per class
   always_comb begin
      if (op_1) begin
         wb_en   = (fn <= OP_SHA[3:0]) || (fn == OP_GETF[3:0]);
         flag_en = fn inside {[OP_NOT[3:0]:4'hd], OP_SETF[3:0]};
      end else begin
         wb_en   = !(fn inside {OP_CMP[3:0], 4'hb, OP_TEST[3:0]}) &&
                   !(op_2reg && (fn inside {4'h1, 4'h2}));  // empty reg slots
         flag_en = fn inside {[OP_ADD[3:0]:OP_MUL[3:0]], [OP_TEST[3:0]:OP_AND[3:0]]};
      end
   end

endmodule

// File: src/reg_file.sv
module reg_file
   import cpu_types_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  reg_idx_t ra,
   input  reg_idx_t rb,
   output word_t    da,
   output word_t    db,
   input  logic     we,
   input  reg_idx_t wa,
   input  word_t    wd
);

   word_t regs [NUM_REGS];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wa] <= wd;
      end
   end

   // reads see the old value in the write cycle
   assign da = regs[ra];
   assign db = regs[rb];

   a_wa_known: assert property (
      @(posedge clk) disable iff (!arst_n)
      we |-> !$isunknown(wa)
   ) else $error("register write with unknown address");

endmodule

// File: src/exec_pipe.sv
module exec_pipe
   import cpu_types_pkg::*;
(
   input  logic                clk,
   input  logic                arst_n,
   input  logic                cmd_valid,
   output logic                cmd_ready,
   input  alu_op_pkg::opcode_t cmd_op,
   input  reg_idx_t            cmd_rd,
   input  reg_idx_t            cmd_rs,
   input  imm_t                cmd_im,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output word_t               rsp_res,
   output flags_t              rsp_flags,
   output reg_idx_t            rsp_rd,
   output logic                rsp_wb,
   output logic                rsp_flag_wr,
   output alu_op_pkg::opcode_t alu_op,
   output imm_t                alu_im,
   output flags_t              alu_fi,
   input  word_t               alu_res,
   input  flags_t              alu_fo,
   input  logic                alu_wb_en,
   input  logic                alu_flag_en,
   output reg_idx_t            rf_ra,
   output reg_idx_t            rf_rb,
   output logic                rf_we,
   output reg_idx_t            rf_wa,
   output word_t               rf_wd
);

   logic                s1_valid;
   logic                s2_valid;
   logic                accept;
   logic                adv;
   alu_op_pkg::opcode_t s1_op;
   reg_idx_t            s1_rd;
   reg_idx_t            s1_rs;
   imm_t                s1_im;
   flags_t              flag_q;
   flags_t              flag_next;

   assign adv       = s1_valid && (!s2_valid || rsp_ready);  // stage 2 free or draining
   assign cmd_ready = !s1_valid || adv;
   assign accept    = cmd_valid && cmd_ready;
   assign rsp_valid = s2_valid;

   assign alu_op = s1_op;
   assign alu_im = s1_im;
   assign alu_fi = flag_q;
   assign rf_ra  = s1_rd;  // rd is also the first source
   assign rf_rb  = s1_rs;

   // commit happens once, when the command leaves stage 1
   assign rf_we     = adv && alu_wb_en;
   assign rf_wa     = s1_rd;
   assign rf_wd     = alu_res;
   assign flag_next = alu_flag_en ? alu_fo : flag_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
         flag_q   <= '0;
      end else begin
         if (accept)
            s1_valid <= 1'b1;
         else if (adv)
            s1_valid <= 1'b0;
         if (adv)
            s2_valid <= 1'b1;
         else if (rsp_ready)
            s2_valid <= 1'b0;
         if (adv)
            flag_q <= flag_next;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         s1_op <= cmd_op;
         s1_rd <= cmd_rd;
         s1_rs <= cmd_rs;
         s1_im <= cmd_im;
      end
      if (adv) begin
         rsp_res     <= alu_res;
         rsp_flags   <= flag_next;  // flags as committed
         rsp_rd      <= s1_rd;
         rsp_wb      <= alu_wb_en;
         rsp_flag_wr <= alu_flag_en;
      end
   end

   a_rsp_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      rsp_valid && !rsp_ready |=>
         rsp_valid && $stable({rsp_res, rsp_flags, rsp_rd, rsp_wb, rsp_flag_wr})
   ) else $error("response changed while stalled");

   // stage 1 left empty by this edge
   a_ready_when_empty: assert property (
      @(posedge clk) disable iff (!arst_n)
      !accept && (!s1_valid || adv) |=> cmd_ready
   ) else $error("cmd_ready low with empty stage 1");

endmodule

// File: src/exec_top.sv
module exec_top
   import cpu_types_pkg::*;
(
   input  logic                clk,
   input  logic                arst_n,
   input  logic                cmd_valid,
   output logic                cmd_ready,
   input  alu_op_pkg::opcode_t cmd_op,
   input  reg_idx_t            cmd_rd,
   input  reg_idx_t            cmd_rs,
   input  imm_t                cmd_im,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output word_t               rsp_res,
   output flags_t              rsp_flags,
   output reg_idx_t            rsp_rd,
   output logic                rsp_wb,
   output logic                rsp_flag_wr
);

   alu_op_pkg::opcode_t alu_op;
   imm_t                alu_im;
   flags_t              alu_fi;
   word_t               alu_res;
   flags_t              alu_fo;
   logic                alu_wb_en;
   logic                alu_flag_en;
   reg_idx_t            rf_ra;
   reg_idx_t            rf_rb;
   word_t               rf_da;
   word_t               rf_db;
   logic                rf_we;
   reg_idx_t            rf_wa;
   word_t               rf_wd;

   exec_pipe pipe_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .cmd_op      (cmd_op),
      .cmd_rd      (cmd_rd),
      .cmd_rs      (cmd_rs),
      .cmd_im      (cmd_im),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp_res     (rsp_res),
      .rsp_flags   (rsp_flags),
      .rsp_rd      (rsp_rd),
      .rsp_wb      (rsp_wb),
      .rsp_flag_wr (rsp_flag_wr),
      .alu_op      (alu_op),
      .alu_im      (alu_im),
      .alu_fi      (alu_fi),
      .alu_res     (alu_res),
      .alu_fo      (alu_fo),
      .alu_wb_en   (alu_wb_en),
      .alu_flag_en (alu_flag_en),
      .rf_ra       (rf_ra),
      .rf_rb       (rf_rb),
      .rf_we       (rf_we),
      .rf_wa       (rf_wa),
      .rf_wd       (rf_wd)
   );

   reg_file rf_i (
      .clk    (clk),
      .arst_n (arst_n),
      .ra     (rf_ra),
      .rb     (rf_rb),
      .da     (rf_da),
      .db     (rf_db),
      .we     (rf_we),
      .wa     (rf_wa),
      .wd     (rf_wd)
   );

   alu alu_i (
      .op      (alu_op),
      .fi      (alu_fi),
      .di      (rf_da),
      .bi      (rf_db),
      .im      (alu_im),
      .res     (alu_res),
      .fo      (alu_fo),
      .wb_en   (alu_wb_en),
      .flag_en (alu_flag_en)
   );

endmodule

// File: testbench/tb_clock.sv
module tb_clock #(
   parameter int PERIOD       = 10,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // released on a falling edge, away from the flops
   initial begin
      arst_n = 1'b0;
      #(PERIOD * RESET_CYCLES) arst_n = 1'b1;
   end

endmodule

// File: testbench/tb_alu_model.sv
module tb_alu_model
   import cpu_types_pkg::*;
   import alu_op_pkg::*;
();

   word_t  regs [NUM_REGS];
   flags_t flags;

   initial begin
      foreach (regs[i]) regs[i] = '0;
      flags = '0;
   end

   // carry from the unsigned sum, overflow when the signed sum leaves the word range
   task automatic add_with_carry(input word_t a, input word_t b, input logic ci,
                                 output word_t s, output logic c, output logic v);
      longint unsigned u;
      longint          t;
      u = longint'(a) + longint'(b) + longint'(ci);
      t = longint'($signed(a)) + longint'($signed(b)) + longint'(ci);
      s = u[31:0];
      c = u[32];
      v = (t != longint'($signed(s)));
   endtask

   // executes one command on the model state, returns what the response should carry
   task automatic predict(input opcode_t op, input reg_idx_t rd, input reg_idx_t rs,
                          input imm_t im, output word_t res, output flags_t fl,
                          output logic wb, output logic fw);
      word_t  a;
      word_t  b;
      word_t  sx;
      word_t  opnd;
      logic   c;
      logic   v;
      flags_t nf;
      a    = regs[rd];
      b    = regs[rs];
      sx   = {{16{im[15]}}, im};
      opnd = op[IMM_BIT] ? sx : b;  // arithmetic immediates are signed
      c    = flags[C_IDX];
      v    = flags[V_IDX];
      res  = a;
      case (op)
         OP_MOV:  res = b;
         OP_SED:  res = b[31] ? 32'hffff_ffff : 32'h0;
         OP_MVL:  res = {a[31:16], im};
         OP_MVH:  res = {im, a[15:0]};
         OP_MVZL: res = {16'h0, im};
         OP_MVS:  res = sx;
         OP_ADD, OP_ADDI, OP_PLUS, OP_PLUSI:
            add_with_carry(a, opnd, 1'b0, res, c, v);
         OP_ADC, OP_ADCI:
            add_with_carry(a, opnd, flags[C_IDX], res, c, v);
         OP_SUB, OP_SUBI, OP_CMP, OP_CMPI:
            add_with_carry(a, ~opnd, 1'b1, res, c, v);
         OP_SBB, OP_SBBI:
            add_with_carry(a, ~opnd, flags[C_IDX], res, c, v);
         OP_MUL, OP_MULI: res = a * opnd;
         OP_TEST, OP_AND: res = a & b;
         OP_TESTI: res = a & {16'h0, im};
         OP_ANDI:  res = a & {16'hffff, im};
         OP_OR:    res = a | b;
         OP_ORI:   res = a | {16'h0, im};
         OP_XOR:   res = a ^ b;
         OP_XORI:  res = a ^ {16'h0, im};
         OP_ZEB:   res = {24'h0, a[7:0]};
         OP_ZEW:   res = {16'h0, a[15:0]};
         OP_SEB:   res = {{24{a[7]}}, a[7:0]};
         OP_SEW:   res = {{16{a[15]}}, a[15:0]};
         OP_NOT:   res = ~a;
         OP_NEG:   add_with_carry(32'h0, ~a, 1'b1, res, c, v);
         OP_ROR: begin
            res = {flags[C_IDX], a[31:1]};
            c   = a[0];
         end
         OP_ROL: begin
            res = {a[30:0], flags[C_IDX]};
            c   = a[31];
         end
         OP_SHL: begin
            res = {a[30:0], 1'b0};
            c   = a[31];
         end
         OP_SHR: begin
            res = {1'b0, a[31:1]};
            c   = a[0];
         end
         OP_SHA: begin
            res = {a[31], a[31:1]};
            c   = a[0];
         end
         OP_GETF: res = {24'h0, flags};
         default: res = a;  // setf passes rd through
      endcase
      wb = !(op inside {OP_CMP, OP_CMPI, OP_TEST, OP_TESTI, OP_SETF});
      fw = !(op inside {OP_MOV, OP_SED, OP_MVL, OP_MVH, OP_MVZL, OP_MVS, OP_PLUS,
                        OP_PLUSI, OP_ZEB, OP_ZEW, OP_SEB, OP_SEW, OP_GETF});
      nf = flags;
      if (op == OP_SETF) begin
         nf = a[7:0];
      end else begin
         nf[C_IDX] = c;
         nf[V_IDX] = v;
         nf[Z_IDX] = (res == 32'h0);
         nf[S_IDX] = res[31];
      end
      if (fw)
         flags = nf;
      if (wb)
         regs[rd] = res;
      fl = flags;
   endtask

endmodule

// File: testbench/tb_exec.sv
module tb_exec
   import cpu_types_pkg::*;
   import alu_op_pkg::*;
();

   localparam int PERIOD         = 10;
   localparam int RESET_CYCLES   = 10;
   localparam int CYCLES_PER_CMD = 20;
   localparam int RANDOM_CMDS    = 200;

   logic     clk;
   logic     arst_n;
   logic     cmd_valid;
   logic     cmd_ready;
   opcode_t  cmd_op;
   reg_idx_t cmd_rd;
   reg_idx_t cmd_rs;
   imm_t     cmd_im;
   logic     rsp_valid;
   logic     rsp_ready;
   word_t    rsp_res;
   flags_t   rsp_flags;
   reg_idx_t rsp_rd;
   logic     rsp_wb;
   logic     rsp_flag_wr;

   word_t    exp_res [$];
   flags_t   exp_flags [$];
   reg_idx_t exp_rd [$];
   logic     exp_wb [$];
   logic     exp_fw [$];
   time      accept_time [$];
   int       issued;
   int       stall_cycles;
   logic     random_ready;
   logic     check_latency;
   word_t    last_res;
   flags_t   last_flags;

   tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_i (
      .clk    (clk),
      .arst_n (arst_n)
   );

   tb_alu_model model_i ();

   exec_top dut_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .cmd_op      (cmd_op),
      .cmd_rd      (cmd_rd),
      .cmd_rs      (cmd_rs),
      .cmd_im      (cmd_im),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp_res     (rsp_res),
      .rsp_flags   (rsp_flags),
      .rsp_rd      (rsp_rd),
      .rsp_wb      (rsp_wb),
      .rsp_flag_wr (rsp_flag_wr)
   );

   task automatic check(input logic [31:0] act, input logic [31:0] exp, input string what);
      if (act !== exp) begin
         $display("error: %0t: %s: got %h, expected %h", $time, what, act, exp);
         $display("TB FAILED");
         $fatal(1, "first mismatch");
      end
   endtask

   // prediction is queued at the accepting edge
   task automatic send(input opcode_t op, input reg_idx_t rd, input reg_idx_t rs,
                       input imm_t im);
      word_t  res;
      flags_t fl;
      logic   wb;
      logic   fw;
      issued++;
      stall_cycles = 0;
      cmd_valid    = 1'b1;
      cmd_op       = op;
      cmd_rd       = rd;
      cmd_rs       = rs;
      cmd_im       = im;
      @(posedge clk);
      while (!cmd_ready) begin
         stall_cycles++;
         @(posedge clk);
      end
      model_i.predict(op, rd, rs, im, res, fl, wb, fw);
      exp_res.push_back(res);
      exp_flags.push_back(fl);
      exp_rd.push_back(rd);
      exp_wb.push_back(wb);
      exp_fw.push_back(fw);
      accept_time.push_back($time);
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   task automatic drain();
      while (exp_res.size() != 0) @(negedge clk);
   endtask

   // slots without a defined operation are never drawn
   function automatic logic usable(opcode_t op);
      if (op[5])
         return !op[4] && !(op[3:0] inside {4'hb, 4'hc, 4'hd});
      if (op[3:0] == 4'hb)
         return 1'b0;
      return op[4] || !(op[3:0] inside {4'h1, 4'h2});
   endfunction

   always @(negedge clk) begin
      rsp_ready = random_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
   end

   always @(posedge clk) begin
      if (arst_n && rsp_valid && rsp_ready) begin
         check(exp_res.size() != 0, 1'b1, "response with no command outstanding");
         check(rsp_res, exp_res.pop_front(), "result");
         check(rsp_flags, exp_flags.pop_front(), "flags");
         check(rsp_rd, exp_rd.pop_front(), "destination index");
         check(rsp_wb, exp_wb.pop_front(), "register write enable");
         check(rsp_flag_wr, exp_fw.pop_front(), "flag write enable");
         if (check_latency)
            check(32'($time - accept_time[0]), 2 * PERIOD, "accept to response time");
         void'(accept_time.pop_front());
         last_res   = rsp_res;
         last_flags = rsp_flags;
      end
   end

   task automatic test_reset();
      check(rsp_valid, 1'b0, "rsp_valid after reset");
      check(cmd_ready, 1'b1, "cmd_ready after reset");
      send(OP_GETF, 4'd1, 4'd0, 16'h0);
      drain();
      check(last_res, 32'h0, "flag register after reset");
   endtask

   task automatic test_moves_and_arith();
      opcode_t ops [12];
      ops = '{OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_CMP, OP_MUL, OP_PLUS, OP_TEST, OP_OR,
              OP_XOR, OP_AND, OP_SED};
      send(OP_MVZL, 4'd1, 4'd0, 16'h1234);
      send(OP_MVH, 4'd1, 4'd0, 16'h8000);  // 8000_1234
      send(OP_MVZL, 4'd2, 4'd0, 16'hffff);
      send(OP_MVS, 4'd3, 4'd0, 16'h8001);  // ffff_8001
      send(OP_MVL, 4'd4, 4'd0, 16'h7fff);
      send(OP_MVH, 4'd4, 4'd0, 16'h7fff);  // 7fff_7fff
      drain();
      check(last_res, 32'h7fff_7fff, "r4 built by mvl and mvh");
      foreach (ops[k]) begin
         for (int a = 1; a <= 4; a++) begin
            for (int b = 1; b <= 4; b++) begin
               send(OP_MOV, 4'd8, reg_idx_t'(a), 16'h0);
               send(ops[k], 4'd8, reg_idx_t'(b), 16'h0);
            end
         end
      end
      send(OP_MOV, 4'd8, 4'd4, 16'h0);
      send(OP_ADD, 4'd8, 4'd4, 16'h0);  // two positives wrap negative
      drain();
      check(last_flags[V_IDX], 1'b1, "overflow on 7fff_7fff doubled");
   endtask

   task automatic test_carry_chain();
      send(OP_MVZL, 4'd1, 4'd0, 16'hffff);
      send(OP_MVH, 4'd1, 4'd0, 16'hffff);
      send(OP_MVZL, 4'd2, 4'd0, 16'h0001);
      send(OP_MVZL, 4'd3, 4'd0, 16'h0001);
      send(OP_MVZL, 4'd4, 4'd0, 16'h0000);
      send(OP_ADD, 4'd1, 4'd3, 16'h0);  // low word carries out
      send(OP_ADC, 4'd2, 4'd4, 16'h0);
      drain();
      check(last_res, 32'h2, "high word of 64-bit add");
      send(OP_SUB, 4'd1, 4'd3, 16'h0);  // low word borrows
      send(OP_SBB, 4'd2, 4'd4, 16'h0);
      drain();
      check(last_res, 32'h1, "high word of 64-bit subtract");
      send(OP_MVZL, 4'd5, 4'd0, 16'h0001);
      send(OP_MVH, 4'd5, 4'd0, 16'h8000);
      send(OP_SHL, 4'd5, 4'd0, 16'h0);
      drain();
      check(last_flags[C_IDX], 1'b1, "bit shifted out by shl");
      send(OP_ROR, 4'd5, 4'd0, 16'h0);
      send(OP_ROL, 4'd5, 4'd0, 16'h0);
      send(OP_SHR, 4'd5, 4'd0, 16'h0);
      send(OP_MVH, 4'd5, 4'd0, 16'h8000);
      send(OP_SHA, 4'd5, 4'd0, 16'h0);
      send(OP_NEG, 4'd5, 4'd0, 16'h0);
      send(OP_NOT, 4'd5, 4'd0, 16'h0);
      drain();
   endtask

   task automatic test_flags_only();
      send(OP_MVZL, 4'd6, 4'd0, 16'h0055);
      send(OP_CMPI, 4'd6, 4'd0, 16'h0054);  // clears Z
      send(OP_TESTI, 4'd6, 4'd0, 16'h00aa);
      send(OP_MOV, 4'd9, 4'd6, 16'h0);
      drain();
      check(last_res, 32'h55, "r6 after cmp and test");
      check(last_flags[Z_IDX], 1'b1, "zero flag from test");
      send(OP_MVZL, 4'd7, 4'd0, 16'h00a5);
      send(OP_SETF, 4'd7, 4'd0, 16'h0);
      send(OP_GETF, 4'd10, 4'd0, 16'h0);
      drain();
      check(last_res, 32'ha5, "flags loaded by setf");
   endtask

   task automatic test_random();
      opcode_t op;
      random_ready = 1'b1;
      repeat (RANDOM_CMDS) begin
         do
            op = opcode_t'($urandom);
         while (!usable(op));
         send(op, reg_idx_t'($urandom), reg_idx_t'($urandom), imm_t'($urandom));
      end
      drain();
      random_ready = 1'b0;
   endtask

   task automatic test_latency();
      @(negedge clk);
      check_latency = 1'b1;
      for (int i = 0; i < 8; i++) begin
         send(OP_ADDI, reg_idx_t'(i), reg_idx_t'(i + 1), imm_t'(i * 3 + 1));
         check(stall_cycles, 0, "command stalled with rsp_ready high");
      end
      drain();
      check_latency = 1'b0;
   endtask

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < RESET_CYCLES + CYCLES_PER_CMD * (issued + 1)) begin
         @(negedge clk);
         cycles++;
      end
      $display("timeout: run stopped after %0d cycles with %0d commands issued",
               cycles, issued);
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(32'h8eb5_65ce));
      cmd_valid     = 1'b0;
      cmd_op        = '0;
      cmd_rd        = '0;
      cmd_rs        = '0;
      cmd_im        = '0;
      rsp_ready     = 1'b1;
      random_ready  = 1'b0;
      check_latency = 1'b0;
      issued        = 0;
      stall_cycles  = 0;
      last_res      = '0;
      last_flags    = '0;
      wait (arst_n === 1'b1);
      @(negedge clk);
      test_reset();
      test_moves_and_arith();
      test_carry_chain();
      test_flags_only();
      test_random();
      test_latency();
      check(exp_res.size(), 0, "responses still outstanding");
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: sources.f
src/cpu_types_pkg.sv
src/alu_op_pkg.sv
src/adder.sv
src/alu.sv
src/reg_file.sv
src/exec_pipe.sv
src/exec_top.sv
testbench/tb_clock.sv
testbench/tb_alu_model.sv
testbench/tb_exec.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - src/cpu_types_pkg.sv
  - src/alu_op_pkg.sv
  - src/adder.sv
  - src/alu.sv
  - src/reg_file.sv
  - src/exec_pipe.sv
  - src/exec_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_alu_model.sv
      - testbench/tb_exec.sv
